/* design/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define WORD_SIZE 16

`define REG_COUNT 4
`define REG_IDX_W 2

// once HLT reaches writeback the pc and stage registers stop
`define HALT_FREEZE 1'b1

`endif

/* design/isaPkg.sv */
package isaPkg;

    // instr[15:12]
    typedef enum logic [3:0] {
        opBne   = 4'd0,
        opBeq   = 4'd1,
        opAdi   = 4'd4,
        opLhi   = 4'd6,
        opLwd   = 4'd7,
        opSwd   = 4'd8,
        opJmp   = 4'd9,
        opRtype = 4'd15
    } opcodeE;

    // instr[5:0], r-type only
    typedef enum logic [5:0] {
        funcAdd = 6'd0,
        funcSub = 6'd1,
        funcAnd = 6'd2,
        funcOrr = 6'd3,
        funcWwd = 6'd28,
        funcHlt = 6'd29
    } funcE;

    typedef enum logic [2:0] {
        aluAdd   = 3'd0,
        aluSub   = 3'd1,
        aluAnd   = 3'd2,
        aluOr    = 3'd3,
        aluPassB = 3'd4
    } aluOpE;

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  aluSrcImm;   // operand b from the immediate
        aluOpE aluOp;
        logic  isWwd;
        logic  isHalt;
        logic  valid;       // 0 for bubbles
    } ctrlT;

endpackage

/* design/pipePkg.sv */
`include "cpu_consts.svh"

package pipePkg;
    import isaPkg::*;

    typedef struct packed {
        logic                  valid;   // cleared on flush
        logic [`WORD_SIZE-1:0] pc;
        logic [`WORD_SIZE-1:0] instr;
    } ifIdT;

    typedef struct packed {
        ctrlT                  ctrl;
        logic [`WORD_SIZE-1:0] pc;
        logic [`WORD_SIZE-1:0] rsVal;
        logic [`WORD_SIZE-1:0] rtVal;
        logic [`WORD_SIZE-1:0] imm;
        logic [`REG_IDX_W-1:0] rsIdx;
        logic [`REG_IDX_W-1:0] rtIdx;
        logic [`REG_IDX_W-1:0] rdIdx;
    } idExT;

    typedef struct packed {
        ctrlT                  ctrl;
        logic [`WORD_SIZE-1:0] aluResult;
        logic [`WORD_SIZE-1:0] storeData;
        logic [`WORD_SIZE-1:0] rsVal;     // forwarded, for WWD
        logic [`REG_IDX_W-1:0] rdIdx;
    } exMemT;

    typedef struct packed {
        ctrlT                  ctrl;
        logic [`WORD_SIZE-1:0] memData;
        logic [`WORD_SIZE-1:0] aluResult;
        logic [`WORD_SIZE-1:0] rsVal;
        logic [`REG_IDX_W-1:0] rdIdx;
    } memWbT;

    typedef enum logic [1:0] {
        fwdRegFile = 2'd0,
        fwdExMem   = 2'd1,
        fwdWb      = 2'd2
    } fwdSelE;

endpackage

/* design/regFile.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module regFile (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [`REG_IDX_W-1:0] rsIdx,
    input  logic [`REG_IDX_W-1:0] rtIdx,
    input  logic [`REG_IDX_W-1:0] wrIdx,
    input  logic [`WORD_SIZE-1:0] wrData,
    input  logic                  wrEn,
    output logic [`WORD_SIZE-1:0] rsData,
    output logic [`WORD_SIZE-1:0] rtData
);

    logic [`WORD_SIZE-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (wrEn) begin
            regs[wrIdx] <= wrData;
        end
    end

    // write-through so decode sees the value being written back
    assign rsData = (wrEn && wrIdx == rsIdx) ? wrData : regs[rsIdx];
    assign rtData = (wrEn && wrIdx == rtIdx) ? wrData : regs[rtIdx];

endmodule

/* design/aluUnit.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module aluUnit import isaPkg::*; (
    input  logic [`WORD_SIZE-1:0] opA,
    input  logic [`WORD_SIZE-1:0] opB,
    input  aluOpE                 aluOp,
    output logic [`WORD_SIZE-1:0] result
);

    always_comb begin
        case (aluOp)
            aluAdd: begin
                result = opA + opB;
            end
            aluSub: begin
                result = opA - opB;
            end
            aluAnd: begin
                result = opA & opB;
            end
            aluOr: begin
                result = opA | opB;
            end
            aluPassB: begin
                result = opB;   // lhi, imm already in the high byte
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* design/controlDecoder.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module controlDecoder import isaPkg::*; (
    input  logic [`WORD_SIZE-1:0] instr,
    input  logic [`WORD_SIZE-1:0] pc,
    input  logic [`WORD_SIZE-1:0] rsData,
    input  logic [`WORD_SIZE-1:0] rtData,
    output ctrlT                  ctrl,
    output logic [`WORD_SIZE-1:0] imm,
    output logic [`REG_IDX_W-1:0] rdIdx,
    output logic                  redirect,
    output logic [`WORD_SIZE-1:0] target
);

    opcodeE                opcode;
    funcE                  func;
    logic [`WORD_SIZE-1:0] branchTarget;

    assign opcode = opcodeE'(instr[15:12]);
    assign func   = funcE'(instr[5:0]);

    assign imm = (opcode == opLhi) ? {instr[7:0], {(`WORD_SIZE-8){1'b0}}}
                                   : {{(`WORD_SIZE-8){instr[7]}}, instr[7:0]};

    always_comb begin
        ctrl  = '0;
        rdIdx = '0;
        case (opcode)
            opAdi, opLhi, opLwd: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = (opcode == opLhi) ? aluPassB : aluAdd;
                ctrl.memRead   = (opcode == opLwd);
                ctrl.memToReg  = (opcode == opLwd);
                ctrl.valid     = 1'b1;
                rdIdx          = instr[9:8];   // rt is the destination
            end
            opSwd: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.valid     = 1'b1;
            end
            opBne, opBeq, opJmp: begin
                ctrl.valid = 1'b1;
            end
            opRtype: begin
                rdIdx      = instr[7:6];
                ctrl.valid = 1'b1;
                case (func)
                    funcAdd: ctrl.aluOp = aluAdd;
                    funcSub: ctrl.aluOp = aluSub;
                    funcAnd: ctrl.aluOp = aluAnd;
                    funcOrr: ctrl.aluOp = aluOr;
                    funcWwd: ctrl.isWwd = 1'b1;
                    funcHlt: ctrl.isHalt = 1'b1;
                    default: ctrl.valid = 1'b0;
                endcase
                ctrl.regWrite = ctrl.valid && !ctrl.isWwd && !ctrl.isHalt;
            end
            default: begin
                ctrl = '0;   // unknown opcode retires nothing
            end
        endcase
    end

    assign branchTarget = pc + `WORD_SIZE'(1) + imm;

    always_comb begin
        target = branchTarget;
        case (opcode)
            opBne: redirect = (rsData != rtData);
            opBeq: redirect = (rsData == rtData);
            opJmp: begin
                redirect = 1'b1;
                target   = {pc[`WORD_SIZE-1:12], instr[11:0]};
            end
            default: redirect = 1'b0;
        endcase
    end

endmodule

/* design/hazardUnit.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module hazardUnit import isaPkg::*, pipePkg::*; (
    input  logic                  ifIdValid,
    input  opcodeE                opcode,
    input  logic [`REG_IDX_W-1:0] rsIdx,
    input  logic [`REG_IDX_W-1:0] rtIdx,
    input  idExT                  idEx,
    input  exMemT                 exMem,
    input  memWbT                 memWb,
    input  logic                  redirect,
    output logic                  pcHold,
    output logic                  ifIdHold,
    output logic                  idExBubble,
    output logic                  ifIdFlush,
    output fwdSelE                fwdA,
    output fwdSelE                fwdB
);

    logic isBranch;
    logic usesRs;
    logic usesRt;
    logic loadUse;
    logic branchWait;
    logic stall;

    function automatic fwdSelE pickSrc(input logic [`REG_IDX_W-1:0] idx,
                                       input exMemT em, input memWbT mw);
        fwdSelE sel;
        sel = fwdRegFile;
        if (mw.ctrl.valid && mw.ctrl.regWrite && mw.rdIdx == idx)
            sel = fwdWb;
        if (em.ctrl.valid && em.ctrl.regWrite && em.rdIdx == idx)
            sel = fwdExMem;   // newer value wins
        return sel;
    endfunction

    assign isBranch = ifIdValid && (opcode == opBne || opcode == opBeq);
    assign usesRs   = ifIdValid && opcode != opLhi && opcode != opJmp;
    assign usesRt   = isBranch || (ifIdValid && (opcode == opRtype || opcode == opSwd));

    assign loadUse = idEx.ctrl.valid && idEx.ctrl.memRead &&
                     ((usesRs && idEx.rdIdx == rsIdx) || (usesRt && idEx.rdIdx == rtIdx));

    // branches compare in decode, wait until the operand is in writeback
    assign branchWait = isBranch &&
        ((idEx.ctrl.valid && idEx.ctrl.regWrite &&
          (idEx.rdIdx == rsIdx || idEx.rdIdx == rtIdx)) ||
         (exMem.ctrl.valid && exMem.ctrl.regWrite &&
          (exMem.rdIdx == rsIdx || exMem.rdIdx == rtIdx)));

    assign stall      = loadUse || branchWait;
    assign pcHold     = stall;
    assign ifIdHold   = stall;
    assign idExBubble = stall;
    assign ifIdFlush  = redirect && !stall;

    assign fwdA = pickSrc(idEx.rsIdx, exMem, memWb);
    assign fwdB = pickSrc(idEx.rtIdx, exMem, memWb);

endmodule

/* design/pipeStage.sv */
`timescale 1ns/1ps

module pipeStage #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    hold,
    input  logic    bubble,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            q <= '0;
        end else if (hold) begin
            q <= q;
        end else if (bubble) begin
            q <= '0;   // valid bit drops with the rest
        end else begin
            q <= d;
        end
    end

endmodule

/* design/cpuCore.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpuCore import isaPkg::*, pipePkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [`WORD_SIZE-1:0] data1,
    input  logic [`WORD_SIZE-1:0] readData2,
    output logic                  readM1,
    output logic [`WORD_SIZE-1:0] address1,
    output logic                  readM2,
    output logic                  writeM2,
    output logic [`WORD_SIZE-1:0] address2,
    output logic [`WORD_SIZE-1:0] writeData2,
    output logic [`WORD_SIZE-1:0] numInst,
    output logic [`WORD_SIZE-1:0] outputPort,
    output logic                  outputValid,
    output logic                  isHalted
);

    logic [`WORD_SIZE-1:0] pc;
    ifIdT                  ifIdD;
    ifIdT                  ifIdQ;
    idExT                  idExD;
    idExT                  idExQ;
    exMemT                 exMemD;
    exMemT                 exMemQ;
    memWbT                 memWbD;
    memWbT                 memWbQ;

    ctrlT                  decCtrl;
    logic [`WORD_SIZE-1:0] decImm;
    logic [`REG_IDX_W-1:0] decRd;
    logic                  redirect;
    logic                  redirectV;
    logic [`WORD_SIZE-1:0] target;
    logic [`WORD_SIZE-1:0] rsData;
    logic [`WORD_SIZE-1:0] rtData;

    logic                  pcHold;
    logic                  ifIdHold;
    logic                  idExBubble;
    logic                  ifIdFlush;
    fwdSelE                fwdA;
    fwdSelE                fwdB;

    logic [`WORD_SIZE-1:0] opA;
    logic [`WORD_SIZE-1:0] rtFwd;
    logic [`WORD_SIZE-1:0] opB;
    logic [`WORD_SIZE-1:0] aluResult;
    logic [`WORD_SIZE-1:0] wbData;
    logic                  wbEn;
    logic                  haltInWb;
    logic                  freeze;

    assign haltInWb = memWbQ.ctrl.valid && memWbQ.ctrl.isHalt;
    assign freeze   = `HALT_FREEZE && (isHalted || haltInWb);

    // fetch
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (!(pcHold || freeze)) begin
            pc <= redirectV ? target : pc + `WORD_SIZE'(1);
        end
    end

    assign readM1   = !isHalted;
    assign address1 = pc;
    assign ifIdD    = '{valid: readM1, pc: pc, instr: data1};

    pipeStage #(.payloadT(ifIdT)) ifIdReg (
        .clk(clk), .rstN(rstN), .hold(ifIdHold || freeze), .bubble(ifIdFlush),
        .d(ifIdD), .q(ifIdQ)
    );

    // decode
    regFile regs (
        .clk(clk), .rstN(rstN),
        .rsIdx(ifIdQ.instr[11:10]), .rtIdx(ifIdQ.instr[9:8]),
        .wrIdx(memWbQ.rdIdx), .wrData(wbData), .wrEn(wbEn),
        .rsData(rsData), .rtData(rtData)
    );

    controlDecoder decoder (
        .instr(ifIdQ.instr), .pc(ifIdQ.pc), .rsData(rsData), .rtData(rtData),
        .ctrl(decCtrl), .imm(decImm), .rdIdx(decRd), .redirect(redirect), .target(target)
    );

    assign redirectV = redirect && ifIdQ.valid;   // flushed slot never redirects

    hazardUnit hazards (
        .ifIdValid(ifIdQ.valid), .opcode(opcodeE'(ifIdQ.instr[15:12])),
        .rsIdx(ifIdQ.instr[11:10]), .rtIdx(ifIdQ.instr[9:8]),
        .idEx(idExQ), .exMem(exMemQ), .memWb(memWbQ), .redirect(redirectV),
        .pcHold(pcHold), .ifIdHold(ifIdHold), .idExBubble(idExBubble),
        .ifIdFlush(ifIdFlush), .fwdA(fwdA), .fwdB(fwdB)
    );

    assign idExD = '{ctrl: ifIdQ.valid ? decCtrl : ctrlT'('0), pc: ifIdQ.pc,
                     rsVal: rsData, rtVal: rtData, imm: decImm,
                     rsIdx: ifIdQ.instr[11:10], rtIdx: ifIdQ.instr[9:8], rdIdx: decRd};

    pipeStage #(.payloadT(idExT)) idExReg (
        .clk(clk), .rstN(rstN), .hold(freeze), .bubble(idExBubble),
        .d(idExD), .q(idExQ)
    );

    // execute
    always_comb begin
        case (fwdA)
            fwdExMem: opA = exMemQ.aluResult;
            fwdWb:    opA = wbData;
            default:  opA = idExQ.rsVal;
        endcase
        case (fwdB)
            fwdExMem: rtFwd = exMemQ.aluResult;
            fwdWb:    rtFwd = wbData;
            default:  rtFwd = idExQ.rtVal;
        endcase
    end

    assign opB = idExQ.ctrl.aluSrcImm ? idExQ.imm : rtFwd;

    aluUnit alu (.opA(opA), .opB(opB), .aluOp(idExQ.ctrl.aluOp), .result(aluResult));

    assign exMemD = '{ctrl: idExQ.ctrl, aluResult: aluResult, storeData: rtFwd,
                      rsVal: opA, rdIdx: idExQ.rdIdx};

    pipeStage #(.payloadT(exMemT)) exMemReg (
        .clk(clk), .rstN(rstN), .hold(freeze), .bubble(1'b0),
        .d(exMemD), .q(exMemQ)
    );

    // memory, nothing past HLT touches the data port
    assign readM2     = exMemQ.ctrl.memRead && !freeze;
    assign writeM2    = exMemQ.ctrl.memWrite && !freeze;
    assign address2   = exMemQ.aluResult;
    assign writeData2 = exMemQ.storeData;

    assign memWbD = '{ctrl: exMemQ.ctrl, memData: readData2, aluResult: exMemQ.aluResult,
                      rsVal: exMemQ.rsVal, rdIdx: exMemQ.rdIdx};

    pipeStage #(.payloadT(memWbT)) memWbReg (
        .clk(clk), .rstN(rstN), .hold(freeze), .bubble(1'b0),
        .d(memWbD), .q(memWbQ)
    );

    // writeback
    assign wbData      = memWbQ.ctrl.memToReg ? memWbQ.memData : memWbQ.aluResult;
    assign wbEn        = memWbQ.ctrl.valid && memWbQ.ctrl.regWrite;
    assign outputPort  = memWbQ.rsVal;
    assign outputValid = memWbQ.ctrl.valid && memWbQ.ctrl.isWwd && !isHalted;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            numInst  <= '0;
            isHalted <= 1'b0;
        end else begin
            if (memWbQ.ctrl.valid && !isHalted)
                numInst <= numInst + `WORD_SIZE'(1);   // HLT itself counts
            if (haltInWb)
                isHalted <= 1'b1;
        end
    end

endmodule

/* sim/cpuCore_asserts.sv */
`timescale 1ns/1ps

module cpuCore_asserts (
    input logic        clk,
    input logic        rstN,
    input logic        readM2,
    input logic        writeM2,
    input logic        outputValid,
    input logic        isHalted,
    input logic [15:0] numInst
);

    // data port strobes are exclusive
    strobeExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(readM2 && writeM2))
        else $error("readM2 and writeM2 high together");

    haltSticky: assert property (@(posedge clk) disable iff (!rstN)
        isHalted |=> isHalted)
        else $error("isHalted dropped without reset");

    quietAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
        isHalted |-> !outputValid && !readM2 && !writeM2)
        else $error("activity after halt");

    resetState: assert property (@(posedge clk)
        !rstN |=> numInst == 16'd0 && !isHalted && !outputValid)
        else $error("outputs not cleared by reset");

endmodule

/* sim/cpuCoreTb.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpuCoreTb;

    logic                  clk;
    logic                  rstN;
    logic [`WORD_SIZE-1:0] data1;
    logic [`WORD_SIZE-1:0] readData2;
    logic                  readM1;
    logic [`WORD_SIZE-1:0] address1;
    logic                  readM2;
    logic                  writeM2;
    logic [`WORD_SIZE-1:0] address2;
    logic [`WORD_SIZE-1:0] writeData2;
    logic [`WORD_SIZE-1:0] numInst;
    logic [`WORD_SIZE-1:0] outputPort;
    logic                  outputValid;
    logic                  isHalted;

    logic [`WORD_SIZE-1:0] imem [64];
    logic [`WORD_SIZE-1:0] dmem [64];
    logic [`WORD_SIZE-1:0] tv [0:127];   // whole test file

    logic                  pendWr;
    logic [5:0]            pendAddr;
    logic [`WORD_SIZE-1:0] pendData;

    int progLen;
    int dataLen;
    int wwdLen;
    int storeLen;
    int wwdBase;
    int wwdCount;
    int cycleCount;
    int cycleLimit;
    int valueErrors;
    int otherErrors;

    cpuCore cpuCore_inst (.*);

    bind cpuCore cpuCore_asserts assertsInst (
        .clk(clk), .rstN(rstN), .readM2(readM2), .writeM2(writeM2),
        .outputValid(outputValid), .isHalted(isHalted), .numInst(numInst)
    );

    always #50 clk = ~clk;

    // memories answer in the same cycle, only while strobed
    assign data1     = readM1 ? imem[address1[5:0]] : '0;
    assign readData2 = readM2 ? dmem[address2[5:0]] : '0;

    // store seen mid-cycle lands at the next rising edge
    always @(negedge clk) begin
        pendWr   <= writeM2;
        pendAddr <= address2[5:0];
        pendData <= writeData2;
    end

    always @(posedge clk) begin
        if (pendWr)
            dmem[pendAddr] <= pendData;
    end

    always @(negedge clk) begin
        if (rstN && outputValid) begin
            if (isHalted) begin
                otherErrors++;
                $display("output pulse seen after the core halted");
            end else begin
                if (wwdCount < wwdLen)
                    checkValue($sformatf("wwd %0d", wwdCount), tv[wwdBase + wwdCount],
                               outputPort);
                wwdCount++;   // pulses in order
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: core did not finish within %0d cycles", cycleLimit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [`WORD_SIZE-1:0] expected,
                              input logic [`WORD_SIZE-1:0] actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    initial begin
        int base;
        clk         = 1'b0;
        rstN        = 1'b0;
        pendWr      = 1'b0;
        pendAddr    = '0;
        pendData    = '0;
        cycleCount  = 0;
        wwdCount    = 0;
        valueErrors = 0;
        otherErrors = 0;
        $readmemh("sim/program_tests.txt", tv);
        progLen    = tv[0];
        dataLen    = tv[1];
        wwdLen     = tv[2];
        storeLen   = tv[4];
        wwdBase    = 5 + progLen + dataLen;
        cycleLimit = 20 * progLen + 50;
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < progLen) ? tv[5 + i] : '0;
            dmem[i] = (i < dataLen) ? tv[5 + progLen + i] : (16'hd000 | 16'(i));
        end

        repeat (3) @(posedge clk);
        #5;
        checkValue("reset readM1", 1'b1, readM1);
        checkValue("reset readM2", 1'b0, readM2);
        checkValue("reset writeM2", 1'b0, writeM2);
        checkValue("reset outputValid", 1'b0, outputValid);
        checkValue("reset isHalted", 1'b0, isHalted);
        checkValue("reset numInst", '0, numInst);
        rstN = 1'b1;

        while (!isHalted)
            @(negedge clk);
        repeat (10) begin
            @(negedge clk);
            if (!isHalted) begin
                otherErrors++;
                $display("isHalted dropped after the halt");
            end
        end

        if (wwdCount != wwdLen) begin
            otherErrors++;
            $display("saw %0d output pulses instead of %0d", wwdCount, wwdLen);
        end
        checkValue("halted readM1", 1'b0, readM1);
        checkValue("retired count", tv[3], numInst);
        base = wwdBase + wwdLen;
        for (int i = 0; i < storeLen; i++)
            checkValue($sformatf("store at %0d", tv[base + 2*i]), tv[base + 2*i + 1],
                       dmem[tv[base + 2*i][5:0]]);

        $display("errors: %0d wrong values, %0d other", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* sim/program_tests.txt */
// header: program words, data words, wwd count, retired count, store checks
// then program, initial data, expected wwd values, store address/value pairs
001C 0008 0007 0019 0002
// arithmetic with forwarding
4105 4603 F6C0 FC1C 6112 F781 F81C F6C2
FC1C F9C3 FC1C
// load-use, store
7102 F780 F81C 8205
// taken beq, taken bne, not-taken beq, jmp
1A01 F41C 0601 F41C 1601 F41C 9017 F81C
// reload, stall, store, halt
7305 4F01 8306 FC1C F01D
// initial data words 0..7
A000 A001 0100 A003 A004 A005 A006 A007
// expected wwd values in order
000D 11F3 1000 13F3 14F3 0100 14F4
// stored words
0005 14F3
0006 14F4

/* build.f */
+incdir+design
design/isaPkg.sv
design/pipePkg.sv
design/regFile.sv
design/aluUnit.sv
design/controlDecoder.sv
design/hazardUnit.sv
design/pipeStage.sv
design/cpuCore.sv
sim/cpuCore_asserts.sv
sim/cpuCoreTb.sv

/* run.sh */
#!/bin/sh
# build and run the cpuCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f build.f --top-module cpuCoreTb; then
    echo "build failed"
    exit 1
fi

if ! out=$(./obj_dir/VcpuCoreTb); then
    echo "$out"
    echo "simulation exited with an error"
    exit 1
fi
echo "$out"

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1
